/* common/dcache_pkg.sv */
package dcache_pkg;

	// byte address layout: tag | index | word offset | byte in word
	localparam int ADDR_W = 12;
	localparam int WORD_W = 32;

	// direct mapped, 8 lines of 4 words
	localparam int LINES = 8;
	localparam int WORDS_PER_LINE = 4;

	localparam int TAG_W = 5;
	localparam int IDX_W = 3;
	localparam int BO_W = 2;

	localparam int BO_LSB = 2;
	localparam int IDX_LSB = BO_LSB + BO_W;
	localparam int TAG_LSB = IDX_LSB + IDX_W;

	// backing memory
	localparam int MEM_WORDS = 1024;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int MEM_WAIT = 2;
	localparam int WAIT_W = $clog2(MEM_WAIT + 1);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [BO_W-1:0] bo_t;
	typedef logic [WAIT_W-1:0] wait_cnt_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// word 0 sits in the low bits
	typedef word_t [WORDS_PER_LINE-1:0] line_data_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		word_t dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_rsp_t;

endpackage

/* cache/line_store.sv */
`timescale 1ns/1ps

module line_store #(
	parameter type entry_t = logic
) (
	input logic CLK,
	input logic arst_n,

	input logic wen,
	input dcache_pkg::idx_t widx,
	input entry_t wdata,

	input dcache_pkg::idx_t ridx,
	output entry_t rdata
);

	entry_t entries [dcache_pkg::LINES];

	// one entry per cache line, all cleared so every tag starts invalid
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dcache_pkg::LINES; i++) begin
				entries[i] <= '0;
			end
		end else if (wen) begin
			entries[widx] <= wdata;
		end
	end

	// async read port
	assign rdata = entries[ridx];

endmodule

/* cache/dcache.sv */
`timescale 1ns/1ps

module dcache (
	input logic CLK,
	input logic arst_n,

	input dcache_pkg::wb_req_t cpu_req,
	output dcache_pkg::wb_rsp_t cpu_rsp,

	output dcache_pkg::wb_req_t mem_req,
	input dcache_pkg::wb_rsp_t mem_rsp
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HIT_REPLY,
		S_REFILL,
		S_REFILL_REPLY,
		S_WRITE_THRU,
		S_WRITE_REPLY
	} state_t;

	state_t state;

	dcache_pkg::tag_t req_tag;
	dcache_pkg::idx_t req_idx;
	dcache_pkg::bo_t req_bo;
	logic req_valid;
	logic hit;

	dcache_pkg::tag_entry_t tag_rd;
	dcache_pkg::tag_entry_t tag_wdata;
	logic tag_wen;

	dcache_pkg::line_data_t data_rd;
	dcache_pkg::line_data_t data_wdata;
	dcache_pkg::line_data_t merged_line;
	dcache_pkg::line_data_t refill_line;
	logic data_wen;

	dcache_pkg::bo_t fill_cnt;
	dcache_pkg::line_data_t fill_line;
	logic refill_last;
	logic write_hit_upd;

	assign req_tag = cpu_req.adr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
	assign req_idx = cpu_req.adr[dcache_pkg::IDX_LSB +: dcache_pkg::IDX_W];
	assign req_bo = cpu_req.adr[dcache_pkg::BO_LSB +: dcache_pkg::BO_W];
	assign req_valid = cpu_req.cyc && cpu_req.stb;

	assign hit = tag_rd.valid && (tag_rd.tag == req_tag);

	line_store #(
		.entry_t(dcache_pkg::tag_entry_t)
	) i_tag_store (
		.CLK(CLK),
		.arst_n(arst_n),
		.wen(tag_wen),
		.widx(req_idx),
		.wdata(tag_wdata),
		.ridx(req_idx),
		.rdata(tag_rd)
	);

	line_store #(
		.entry_t(dcache_pkg::line_data_t)
	) i_data_store (
		.CLK(CLK),
		.arst_n(arst_n),
		.wen(data_wen),
		.widx(req_idx),
		.wdata(data_wdata),
		.ridx(req_idx),
		.rdata(data_rd)
	);

	// write hit replaces one word of the cached line
	always_comb begin
		merged_line = data_rd;
		merged_line[req_bo] = cpu_req.dat;
	end

	// last refill word goes straight in, the rest come from fill_line
	always_comb begin
		refill_line = fill_line;
		refill_line[fill_cnt] = mem_rsp.dat;
	end

	assign refill_last = (state == S_REFILL) && mem_rsp.ack &&
		(fill_cnt == dcache_pkg::bo_t'(dcache_pkg::WORDS_PER_LINE - 1));
	assign write_hit_upd = (state == S_IDLE) && req_valid && cpu_req.we && hit;

	assign data_wen = refill_last || write_hit_upd;
	assign data_wdata = refill_last ? refill_line : merged_line;

	// tag goes valid together with the whole line
	assign tag_wen = refill_last;
	always_comb begin
		tag_wdata.valid = 1'b1;
		tag_wdata.tag = req_tag;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			fill_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_valid) begin
						if (cpu_req.we) begin
							state <= S_WRITE_THRU;
						end else if (hit) begin
							state <= S_HIT_REPLY;
						end else begin
							state <= S_REFILL;
							fill_cnt <= '0;
						end
					end
				end
				S_REFILL: begin
					if (mem_rsp.ack) begin
						if (refill_last) begin
							state <= S_REFILL_REPLY;
						end else begin
							fill_cnt <= fill_cnt + 1'b1;
						end
					end
				end
				S_WRITE_THRU: begin
					if (mem_rsp.ack) begin
						state <= S_WRITE_REPLY;
					end
				end
				// ack is up for this one cycle, then back to idle
				S_HIT_REPLY, S_REFILL_REPLY, S_WRITE_REPLY: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// line assembly buffer
	always_ff @(posedge CLK) begin
		if (state == S_REFILL && mem_rsp.ack) begin
			fill_line[fill_cnt] <= mem_rsp.dat;
		end
	end

	// reply word always comes from the data store
	always_comb begin
		cpu_rsp.ack = (state == S_HIT_REPLY) || (state == S_REFILL_REPLY) ||
			(state == S_WRITE_REPLY);
		cpu_rsp.dat = data_rd[req_bo];
	end

	// cpu request is held steady, so this stays stable until mem ack
	always_comb begin
		mem_req.cyc = 1'b0;
		mem_req.stb = 1'b0;
		mem_req.we = 1'b0;
		mem_req.adr = '0;
		mem_req.dat = '0;
		case (state)
			S_REFILL: begin
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
				mem_req.adr = {req_tag, req_idx, fill_cnt, 2'b00};
			end
			S_WRITE_THRU: begin
				mem_req.cyc = 1'b1;
				mem_req.stb = 1'b1;
				mem_req.we = 1'b1;
				mem_req.adr = cpu_req.adr;
				mem_req.dat = cpu_req.dat;
			end
			default: begin
				mem_req.cyc = 1'b0;
			end
		endcase
	end

endmodule

/* hw/data_mem.sv */
`timescale 1ns/1ps

module data_mem (
	input logic CLK,
	input logic arst_n,

	input dcache_pkg::wb_req_t req,
	output dcache_pkg::wb_rsp_t rsp
);

	dcache_pkg::word_t mem [dcache_pkg::MEM_WORDS];

	logic pending;
	dcache_pkg::wait_cnt_t wait_cnt;
	logic ack;
	logic start;
	logic fire;
	dcache_pkg::word_t rd_dat;
	logic [dcache_pkg::MEM_IDX_W-1:0] word_addr;

	assign word_addr = req.adr[dcache_pkg::BO_LSB +: dcache_pkg::MEM_IDX_W];

	// no new transfer in the ack cycle, the master still shows the old strobe
	assign start = req.cyc && req.stb && !pending && !ack;
	assign fire = pending && (wait_cnt == dcache_pkg::wait_cnt_t'(dcache_pkg::MEM_WAIT));

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			wait_cnt <= '0;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (start) begin
				pending <= 1'b1;
				wait_cnt <= '0;
			end else if (fire) begin
				pending <= 1'b0;
				ack <= 1'b1;
			end else if (pending) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// contents read back as zero after reset
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (fire && req.we) begin
			mem[word_addr] <= req.dat;
		end
	end

	// read data lines up with ack
	always_ff @(posedge CLK) begin
		if (fire && !req.we) begin
			rd_dat <= mem[word_addr];
		end
	end

	always_comb begin
		rsp.ack = ack;
		rsp.dat = rd_dat;
	end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input logic CLK,
	input logic arst_n,

	input dcache_pkg::wb_req_t cpu_req,
	output dcache_pkg::wb_rsp_t cpu_rsp
);

	// cache to backing memory bus
	dcache_pkg::wb_req_t mem_req;
	dcache_pkg::wb_rsp_t mem_rsp;

	dcache i_dcache (
		.CLK(CLK),
		.arst_n(arst_n),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	data_mem i_data_mem (
		.CLK(CLK),
		.arst_n(arst_n),
		.req(mem_req),
		.rsp(mem_rsp)
	);

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM = 200;
	localparam int CYCLES_PER_ENTRY = 20;

	typedef struct packed {
		logic we;
		dcache_pkg::addr_t adr;
		dcache_pkg::word_t dat;
		logic exp_hit;
	} entry_t;

	logic CLK;
	logic arst_n;
	dcache_pkg::wb_req_t cpu_req;
	dcache_pkg::wb_rsp_t cpu_rsp;

	entry_t table_q[$];
	string name_q[$];

	// reference model of backing memory and cache tags
	dcache_pkg::word_t model_mem [dcache_pkg::MEM_WORDS];
	logic model_valid [dcache_pkg::LINES];
	dcache_pkg::tag_t model_tag [dcache_pkg::LINES];

	int word_errs;
	int hit_errs;
	int ack_errs;
	int cycles;
	int timeout_limit;
	logic [31:0] rng;

	dcache_top i_dcache_top (
		.CLK(CLK),
		.arst_n(arst_n),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic model_hit(input dcache_pkg::addr_t adr);
		dcache_pkg::idx_t idx;
		dcache_pkg::tag_t tag;
		idx = adr[dcache_pkg::IDX_LSB +: dcache_pkg::IDX_W];
		tag = adr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
		return model_valid[idx] && (model_tag[idx] == tag);
	endfunction

	task automatic check_word(input string name, input dcache_pkg::word_t exp,
		input dcache_pkg::word_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			word_errs++;
		end
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected hit %b, actual hit %b", name, exp, act);
			hit_errs++;
		end
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected ack %b, actual ack %b", name, exp, act);
			ack_errs++;
		end
	endtask

	task automatic add_entry(input string name, input logic we, input dcache_pkg::addr_t adr,
		input dcache_pkg::word_t dat, input logic exp_hit);
		entry_t e;
		e.we = we;
		e.adr = adr;
		e.dat = dat;
		e.exp_hit = exp_hit;
		table_q.push_back(e);
		name_q.push_back(name);
	endtask

	// one classic cycle on the cpu bus starting on a falling edge
	task automatic do_access(input string name, input logic we, input dcache_pkg::addr_t adr,
		input dcache_pkg::word_t wdat, input logic exp_hit);
		int lat;
		dcache_pkg::word_t got;
		dcache_pkg::idx_t idx;
		logic [dcache_pkg::MEM_IDX_W-1:0] widx;
		idx = adr[dcache_pkg::IDX_LSB +: dcache_pkg::IDX_W];
		widx = adr[dcache_pkg::BO_LSB +: dcache_pkg::MEM_IDX_W];
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we = we;
		cpu_req.adr = adr;
		cpu_req.dat = wdat;
		lat = 0;
		do begin
			@(negedge CLK);
			lat++;
		end while (cpu_rsp.ack !== 1'b1);
		got = cpu_rsp.dat;
		cpu_req = '0;
		// ack lasts one cycle and the cache is back in idle
		@(negedge CLK);
		check_ack(name, 1'b0, cpu_rsp.ack);
		if (we) begin
			model_mem[widx] = wdat;
		end else begin
			check_hit(name, exp_hit, lat == 1);
			check_word(name, model_mem[widx], got);
			// only read misses allocate
			if (!model_hit(adr)) begin
				model_valid[idx] = 1'b1;
				model_tag[idx] = adr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
			end
		end
	endtask

	task automatic build_table();
		add_entry("reset_rd_000", 1'b0, 12'h000, 32'h0, 1'b0);
		add_entry("reset_rd_7f0", 1'b0, 12'h7f0, 32'h0, 1'b0);
		// write miss must not allocate
		add_entry("wmiss_wr", 1'b1, 12'h104, 32'ha5a5_0001, 1'b0);
		add_entry("wmiss_rd", 1'b0, 12'h104, 32'h0, 1'b0);
		add_entry("wmiss_rerd", 1'b0, 12'h104, 32'h0, 1'b1);
		add_entry("wmiss_rd_w0", 1'b0, 12'h100, 32'h0, 1'b1);
		add_entry("wmiss_rd_w2", 1'b0, 12'h108, 32'h0, 1'b1);
		add_entry("wmiss_rd_w3", 1'b0, 12'h10c, 32'h0, 1'b1);
		add_entry("whit_wr", 1'b1, 12'h108, 32'hbeef_0002, 1'b1);
		add_entry("whit_rd", 1'b0, 12'h108, 32'h0, 1'b1);
		add_entry("whit_evict", 1'b0, 12'h208, 32'h0, 1'b0);
		add_entry("whit_reload", 1'b0, 12'h108, 32'h0, 1'b0);
		// same index with tags 0 and 1
		add_entry("conf_a0", 1'b0, 12'h010, 32'h0, 1'b0);
		add_entry("conf_b0", 1'b0, 12'h090, 32'h0, 1'b0);
		add_entry("conf_a1", 1'b0, 12'h010, 32'h0, 1'b0);
		add_entry("conf_b1", 1'b0, 12'h090, 32'h0, 1'b0);
		add_entry("conf_wr", 1'b1, 12'h094, 32'hc0de_0003, 1'b1);
		add_entry("conf_a2", 1'b0, 12'h014, 32'h0, 1'b0);
		add_entry("conf_b2", 1'b0, 12'h094, 32'h0, 1'b0);
	endtask

	initial begin
		cycles = 0;
		@(posedge CLK);
		while (cycles < timeout_limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("run timed out waiting for ack after %0d cycles", cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		dcache_pkg::addr_t adr;
		dcache_pkg::word_t wdat;
		logic we;
		arst_n = 1'b0;
		cpu_req = '0;
		word_errs = 0;
		hit_errs = 0;
		ack_errs = 0;
		rng = 32'hdcf8a700;
		for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < dcache_pkg::LINES; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end
		build_table();
		timeout_limit = (table_q.size() + NUM_RANDOM) * CYCLES_PER_ENTRY + RESET_CYCLES;

		repeat (RESET_CYCLES) @(negedge CLK);
		arst_n = 1'b1;
		@(negedge CLK);
		check_ack("after_reset", 1'b0, cpu_rsp.ack);

		foreach (table_q[i]) begin
			do_access(name_q[i], table_q[i].we, table_q[i].adr, table_q[i].dat,
				table_q[i].exp_hit);
		end

		// tags 0..3 only so lines get reused and evicted
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rng = xorshift32(rng);
			we = (rng[1:0] == 2'b00);
			adr = {3'b000, rng[9:8], rng[14:12], rng[5:4], 2'b00};
			rng = xorshift32(rng);
			wdat = rng;
			do_access($sformatf("rand_%0d", i), we, adr, wdat, model_hit(adr));
		end

		$display("errors: word %0d, hit %0d, ack %0d", word_errs, hit_errs, ack_errs);
		if (word_errs + hit_errs + ack_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* dcache.f */
common/dcache_pkg.sv
cache/line_store.sv
cache/dcache.sv
hw/data_mem.sv
hw/dcache_top.sv
test/tb_dcache.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing -f dcache.f --top-module tb_dcache \
		-Mdir $(OBJ_DIR) -o sim_dcache
	./$(OBJ_DIR)/sim_dcache | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
